//--- hdl/bp_pkg.sv
package bp_pkg;

  typedef logic [7:0] byte_t;

  // Register address, taken from bits 1..0 of a command byte.
  typedef logic [1:0] bp_addr_t;

  localparam bp_addr_t ADDR_WINDOW_EXP = 2'd0;
  localparam bp_addr_t ADDR_PERIOD_EXP = 2'd1;
  localparam bp_addr_t ADDR_FIFO_LEVEL = 2'd2;
  localparam bp_addr_t ADDR_FIFO_DATA  = 2'd3;

  // Command byte bit 7 selects a write.
  localparam int CMD_WRITE_BIT = 7;

  // Command decoder states.
  // CMD waits for a command byte, WDATA for the data byte of a write,
  // and RESP holds a read response until the host takes it.
  typedef enum logic [1:0] {
    CMD,
    WDATA,
    RESP
  } bp_state_t;

endpackage

//--- hdl/bp_reg.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module bp_reg (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  bp_pkg::byte_t         i_bp_data,
  input  logic                  i_bp_valid,
  output logic                  o_bp_ready,
  output bp_pkg::byte_t         o_bp_data,
  output logic                  o_bp_valid,
  input  logic                  i_bp_ready,
  input  bp_pkg::byte_t         i_fifo_data,
  input  corr_pkg::fifo_level_t i_fifo_level,
  output logic                  o_fifo_pop,
  output logic                  o_flush,
  output logic                  o_restart,
  output corr_pkg::window_exp_t o_window_exp,
  output corr_pkg::period_exp_t o_period_exp
);
  import bp_pkg::*;
  import corr_pkg::*;

  bp_state_t   state_q;
  bp_addr_t    addr_q;
  bp_addr_t    cmd_addr;
  byte_t       resp_q;
  byte_t       rd_value;
  window_exp_t window_exp_q;
  window_exp_t window_exp_wr;
  period_exp_t period_exp_q;
  logic        restart_q;
  logic        flush_q;
  logic        cmd_fire;
  logic        data_fire;
  logic        read_fire;

  assign cmd_addr  = bp_addr_t'(i_bp_data[1:0]);
  assign cmd_fire  = (state_q == CMD) && i_bp_valid;
  assign data_fire = (state_q == WDATA) && i_bp_valid;
  assign read_fire = cmd_fire && !i_bp_data[CMD_WRITE_BIT];

  // Commands and write data are taken only while no response is pending.
  assign o_bp_ready = (state_q == CMD) || (state_q == WDATA);
  assign o_bp_valid = (state_q == RESP);
  assign o_bp_data  = resp_q;

  assign o_fifo_pop   = read_fire && (cmd_addr == ADDR_FIFO_DATA) && (i_fifo_level != '0);
  assign o_flush      = flush_q;
  assign o_restart    = restart_q;
  assign o_window_exp = window_exp_q;
  assign o_period_exp = period_exp_q;

  // Window lengths beyond the count width are clamped to the largest window.
  assign window_exp_wr = (i_bp_data > `CORR_MAX_WINDOW_EXP) ?
                         window_exp_t'(`CORR_MAX_WINDOW_EXP) : window_exp_t'(i_bp_data);

  always_comb begin
    case (cmd_addr)
      ADDR_WINDOW_EXP: rd_value = byte_t'(window_exp_q);
      ADDR_PERIOD_EXP: rd_value = byte_t'(period_exp_q);
      ADDR_FIFO_LEVEL: rd_value = byte_t'(i_fifo_level);
      ADDR_FIFO_DATA:  rd_value = i_fifo_data;
      default:         rd_value = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (read_fire) begin
      resp_q <= rd_value;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q      <= CMD;
      addr_q       <= ADDR_WINDOW_EXP;
      window_exp_q <= '0;
      period_exp_q <= '0;
      restart_q    <= 1'b0;
      flush_q      <= 1'b0;
    end else begin
      restart_q <= 1'b0;
      flush_q   <= 1'b0;
      case (state_q)
        CMD: begin
          if (cmd_fire) begin
            addr_q  <= cmd_addr;
            state_q <= i_bp_data[CMD_WRITE_BIT] ? WDATA : RESP;
          end
        end
        WDATA: begin
          if (data_fire) begin
            state_q <= CMD;
            case (addr_q)
              ADDR_WINDOW_EXP: begin
                window_exp_q <= window_exp_wr;
                restart_q    <= 1'b1;
              end
              ADDR_PERIOD_EXP: begin
                period_exp_q <= i_bp_data[2:0];
                restart_q    <= 1'b1;
              end
              ADDR_FIFO_DATA: begin
                flush_q <= 1'b1;
              end
              default: begin
                // The level register is read-only.
              end
            endcase
          end
        end
        RESP: begin
          if (i_bp_ready) begin
            state_q <= CMD;
          end
        end
        default: begin
          state_q <= CMD;
        end
      endcase
    end
  end

endmodule

//--- hdl/byte_fifo.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module byte_fifo (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_flush,
  input  logic                  i_push,
  input  logic                  i_pop,
  input  bp_pkg::byte_t         i_data,
  output bp_pkg::byte_t         o_data,
  output logic                  o_empty,
  output corr_pkg::fifo_level_t o_level
);
  import bp_pkg::*;
  import corr_pkg::*;

  localparam int DEPTH = `CORR_PKTFIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  byte_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  fifo_level_t      level_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  // Pointers wrap at the depth, which need not be a power of two.
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full    = (level_q == fifo_level_t'(DEPTH));
  assign o_empty = (level_q == '0);
  assign o_level = level_q;
  assign o_data  = mem[rd_ptr_q];

  assign do_push = i_push && !full;
  assign do_pop  = i_pop && !o_empty;

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= i_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset || i_flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

endmodule

//--- hdl/corr_count_rect.sv
`timescale 1ns/1ps

module corr_count_rect (
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_strobe,
  input  logic             i_clear,
  input  logic             i_x,
  input  logic             i_y,
  output corr_pkg::count_t o_count_x,
  output corr_pkg::count_t o_count_y,
  output corr_pkg::count_t o_count_isect,
  output corr_pkg::count_t o_count_symdiff
);
  import corr_pkg::*;

  localparam int N_COUNTS = 4;

  // Per-sample contributions in the order x, y, intersection, symmetric difference.
  logic [N_COUNTS-1:0] hit;
  count_t              cnt_q [N_COUNTS];
  count_t              sum   [N_COUNTS];

  assign hit[0] = i_x;
  assign hit[1] = i_y;
  assign hit[2] = i_x & i_y;
  assign hit[3] = i_x ^ i_y;

  // The outputs already include the sample present on this cycle.
  always_comb begin
    for (int i = 0; i < N_COUNTS; i++) begin
      sum[i] = cnt_q[i] + count_t'(hit[i]);
    end
  end

  assign o_count_x       = sum[0];
  assign o_count_y       = sum[1];
  assign o_count_isect   = sum[2];
  assign o_count_symdiff = sum[3];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < N_COUNTS; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (i_strobe) begin
      for (int i = 0; i < N_COUNTS; i++) begin
        cnt_q[i] <= i_clear ? '0 : sum[i];
      end
    end
  end

endmodule

//--- hdl/corr_macros.svh
`ifndef CORR_MACROS_SVH
`define CORR_MACROS_SVH

// Largest window length exponent, so windows run up to 256 samples.
`define CORR_MAX_WINDOW_EXP 8

// Sample index and count width. A full 256-sample window count fits without wrap.
`define CORR_TIME_W 9

// Largest sample period exponent, so the strobe period runs up to 128 cycles.
`define CORR_MAX_PERIOD_EXP 7

// Packet FIFO depth in bytes, enough for four packets.
`define CORR_PKTFIFO_DEPTH 20

// Window number followed by the four count bytes.
`define CORR_PKT_BYTES 5

`endif

//--- hdl/corr_pkg.sv
`include "corr_macros.svh"

package corr_pkg;

  // Sample index within a window, or one of the four window counts.
  typedef logic [`CORR_TIME_W-1:0] count_t;

  // Window length is 2**window_exp samples.
  typedef logic [3:0] window_exp_t;

  // Sample period is 2**period_exp clock cycles.
  typedef logic [2:0] period_exp_t;

  // Number of bytes held in the packet FIFO, 0 to 20.
  typedef logic [4:0] fifo_level_t;

endpackage

//--- hdl/correlator.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module correlator (
  input  logic          i_clk,
  input  logic          i_reset,
  input  logic          i_x,
  input  logic          i_y,
  input  bp_pkg::byte_t i_bp_data,
  input  logic          i_bp_valid,
  output logic          o_bp_ready,
  output bp_pkg::byte_t o_bp_data,
  output logic          o_bp_valid,
  input  logic          i_bp_ready
);
  import corr_pkg::*;
  import bp_pkg::*;

  localparam int TIME_W     = `CORR_TIME_W;
  localparam int PKT_BYTES  = `CORR_PKT_BYTES;
  localparam int FREE_LIMIT = `CORR_PKTFIFO_DEPTH - `CORR_PKT_BYTES;

  window_exp_t window_exp;
  period_exp_t period_exp;
  logic        restart;
  logic        flush;
  logic        fifo_flush;
  logic        clear_all;
  logic        strobe;
  logic        window_end;
  count_t      count_x;
  count_t      count_y;
  count_t      count_isect;
  count_t      count_symdiff;
  count_t      t_q;
  count_t      win_mask;
  byte_t       win_num_q;
  byte_t       pkt_q [PKT_BYTES];
  logic        pkt_busy_q;
  logic [2:0]  pkt_idx_q;
  logic        fifo_push;
  logic        fifo_pop;
  logic        fifo_empty;
  byte_t       fifo_push_data;
  byte_t       fifo_head;
  byte_t       fifo_rd_data;
  fifo_level_t fifo_level;

  // A configuration change starts everything over, a data-register write only drops bytes.
  assign clear_all  = i_reset || restart;
  assign fifo_flush = flush || restart;

  bp_reg u_bp_reg (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_bp_data    (i_bp_data),
    .i_bp_valid   (i_bp_valid),
    .o_bp_ready   (o_bp_ready),
    .o_bp_data    (o_bp_data),
    .o_bp_valid   (o_bp_valid),
    .i_bp_ready   (i_bp_ready),
    .i_fifo_data  (fifo_rd_data),
    .i_fifo_level (fifo_level),
    .o_fifo_pop   (fifo_pop),
    .o_flush      (flush),
    .o_restart    (restart),
    .o_window_exp (window_exp),
    .o_period_exp (period_exp)
  );

  sample_strobe u_sample_strobe (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_restart    (restart),
    .i_period_exp (period_exp),
    .o_strobe     (strobe)
  );

  // The window ends when the low window_exp bits of the sample index are all ones.
  assign win_mask   = count_t'((count_t'(1) << window_exp) - 1'b1);
  assign window_end = strobe && ((t_q & win_mask) == win_mask);

  always_ff @(posedge i_clk) begin
    if (clear_all) begin
      t_q       <= '0;
      win_num_q <= '0;
    end else if (strobe) begin
      t_q <= window_end ? '0 : t_q + 1'b1;
      if (window_end) begin
        win_num_q <= win_num_q + 1'b1;
      end
    end
  end

  corr_count_rect u_corr_count_rect (
    .i_clk           (i_clk),
    .i_reset         (clear_all),
    .i_strobe        (strobe),
    .i_clear         (window_end),
    .i_x             (i_x),
    .i_y             (i_y),
    .o_count_x       (count_x),
    .o_count_y       (count_y),
    .o_count_isect   (count_isect),
    .o_count_symdiff (count_symdiff)
  );

  // Only the top 8 bits of each count are reported.
  always_ff @(posedge i_clk) begin
    if (window_end) begin
      pkt_q[0] <= win_num_q;
      pkt_q[1] <= count_x[TIME_W-1 -: 8];
      pkt_q[2] <= count_y[TIME_W-1 -: 8];
      pkt_q[3] <= count_isect[TIME_W-1 -: 8];
      pkt_q[4] <= count_symdiff[TIME_W-1 -: 8];
    end
  end

  // A packet is sent whole or not at all, depending on the room left at window end.
  always_ff @(posedge i_clk) begin
    if (i_reset || fifo_flush) begin
      pkt_busy_q <= 1'b0;
      pkt_idx_q  <= '0;
    end else if (window_end && (fifo_level <= FREE_LIMIT)) begin
      pkt_busy_q <= 1'b1;
      pkt_idx_q  <= '0;
    end else if (pkt_busy_q) begin
      if (pkt_idx_q == 3'(PKT_BYTES - 1)) begin
        pkt_busy_q <= 1'b0;
        pkt_idx_q  <= '0;
      end else begin
        pkt_idx_q <= pkt_idx_q + 1'b1;
      end
    end
  end

  assign fifo_push      = pkt_busy_q;
  assign fifo_push_data = pkt_q[pkt_idx_q];

  byte_fifo u_byte_fifo (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_flush (fifo_flush),
    .i_push  (fifo_push),
    .i_pop   (fifo_pop),
    .i_data  (fifo_push_data),
    .o_data  (fifo_head),
    .o_empty (fifo_empty),
    .o_level (fifo_level)
  );

  // Reading an empty FIFO returns zero rather than a stale head byte.
  assign fifo_rd_data = fifo_empty ? '0 : fifo_head;

endmodule

//--- hdl/sample_strobe.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module sample_strobe (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_restart,
  input  corr_pkg::period_exp_t i_period_exp,
  output logic                  o_strobe
);

  localparam int PERIOD_W = `CORR_MAX_PERIOD_EXP;

  logic [PERIOD_W:0]   reload_wide;
  logic [PERIOD_W-1:0] reload;
  logic [PERIOD_W-1:0] cnt_q;

  // Reload value is one less than the period, so a zero exponent strobes every cycle.
  assign reload_wide = ({{PERIOD_W{1'b0}}, 1'b1} << i_period_exp) - 1'b1;
  assign reload      = reload_wide[PERIOD_W-1:0];

  // No sample is taken on the cycle the counter is being restarted.
  assign o_strobe = (cnt_q == '0) && !i_restart;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      cnt_q <= '0;
    end else if (i_restart || (cnt_q == '0)) begin
      cnt_q <= reload;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

//--- project.f
+incdir+hdl
+incdir+test
hdl/corr_pkg.sv
hdl/bp_pkg.sv
hdl/sample_strobe.sv
hdl/corr_count_rect.sv
hdl/byte_fifo.sv
hdl/bp_reg.sv
hdl/correlator.sv
test/tb_correlator.sv

//--- test/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

task automatic wait_for_level(input string name, input int min_level, input int max_cycles);
  byte_t b;
  time   start;
  start = $time;
  read_reg(ADDR_FIFO_LEVEL, b);
  while (b < min_level) begin
    if ($time - start > max_cycles * CLK_PERIOD_NS) begin
      stop_run($sformatf("Timeout in %s: the FIFO level stayed at %0d, below %0d.",
                         name, b, min_level));
    end
    read_reg(ADDR_FIFO_LEVEL, b);
  end
endtask

// Pops one packet, checks its four count bytes and hands back its window number.
task automatic pop_packet_checked(input string name, input logic px, input logic py,
                                  input int wexp, output int win);
  byte_t b;
  int    samples;
  samples = 1 << wexp;
  read_reg(ADDR_FIFO_DATA, b);
  win = b;
  read_reg(ADDR_FIFO_DATA, b);
  check_equal({name, " x byte"}, top_byte(px ? samples : 0), b);
  read_reg(ADDR_FIFO_DATA, b);
  check_equal({name, " y byte"}, top_byte(py ? samples : 0), b);
  read_reg(ADDR_FIFO_DATA, b);
  check_equal({name, " intersection byte"}, top_byte((px & py) ? samples : 0), b);
  read_reg(ADDR_FIFO_DATA, b);
  check_equal({name, " symmetric difference byte"}, top_byte((px ^ py) ? samples : 0), b);
endtask

task automatic registers_after_reset();
  byte_t b;
  for (int a = 0; a < 2; a++) begin
    read_reg(bp_addr_t'(a), b);
    check_equal($sformatf("registers_after_reset address %0d", a), 0, b);
  end
  // Both exponents are zero after reset, so a window ends on every cycle and packets flow.
  // The window write restarts and flushes, and the next window end is 256 cycles away.
  write_reg(ADDR_WINDOW_EXP, 8'd12);
  read_reg(ADDR_WINDOW_EXP, b);
  check_equal("registers_after_reset window clamp", `CORR_MAX_WINDOW_EXP, b);
  read_reg(ADDR_FIFO_LEVEL, b);
  check_equal("registers_after_reset level", 0, b);
  read_reg(ADDR_FIFO_DATA, b);
  check_equal("registers_after_reset empty data", 0, b);
  write_reg(ADDR_PERIOD_EXP, 8'h0d);
  read_reg(ADDR_PERIOD_EXP, b);
  check_equal("registers_after_reset period", 8'h0d & 8'h07, b);
endtask

task automatic counts_x_only();
  int win;
  @(negedge clk);
  x = 1'b1;
  y = 1'b0;
  write_reg(ADDR_WINDOW_EXP, 8'd4);
  write_reg(ADDR_PERIOD_EXP, 8'd1);
  wait_for_level("counts_x_only", 3 * PKT, 4 * WIN_SHORT_CYCLES);
  for (int w = 0; w < 3; w++) begin
    pop_packet_checked("counts_x_only", 1'b1, 1'b0, 4, win);
    check_equal("counts_x_only window number", w, win);
  end
endtask

task automatic counts_other_levels();
  int win;
  @(negedge clk);
  x = 1'b1;
  y = 1'b1;
  write_reg(ADDR_PERIOD_EXP, 8'd1);
  wait_for_level("counts_other_levels both high", 3 * PKT, 4 * WIN_SHORT_CYCLES);
  for (int w = 0; w < 3; w++) begin
    pop_packet_checked("counts_other_levels both high", 1'b1, 1'b1, 4, win);
    check_equal("counts_other_levels window number", w, win);
  end
  @(negedge clk);
  x = 1'b0;
  y = 1'b1;
  write_reg(ADDR_WINDOW_EXP, 8'd8);
  wait_for_level("counts_other_levels y only", PKT, 2 * WIN_LONG_CYCLES);
  pop_packet_checked("counts_other_levels y only", 1'b0, 1'b1, 8, win);
  check_equal("counts_other_levels long window number", 0, win);
endtask

task automatic fifo_overflow();
  byte_t b;
  int    win;
  @(negedge clk);
  x = 1'b1;
  y = 1'b0;
  write_reg(ADDR_WINDOW_EXP, 8'd4);
  wait_for_level("fifo_overflow", DEPTH, 6 * WIN_SHORT_CYCLES);
  // Three more windows end while the FIFO has no room.
  repeat (3 * WIN_SHORT_CYCLES) @(negedge clk);
  read_reg(ADDR_FIFO_LEVEL, b);
  check_equal("fifo_overflow level when full", DEPTH, b);
  for (int w = 0; w < DEPTH / PKT; w++) begin
    pop_packet_checked("fifo_overflow", 1'b1, 1'b0, 4, win);
    check_equal("fifo_overflow window number", w, win);
  end
  wait_for_level("fifo_overflow refill", PKT, 3 * WIN_SHORT_CYCLES);
  pop_packet_checked("fifo_overflow after drain", 1'b1, 1'b0, 4, win);
  assert (win > DEPTH / PKT) else begin
    stop_run($sformatf("[FAIL] fifo_overflow window gap: expected above %0d, actual %0d",
                       DEPTH / PKT, win));
  end
endtask

task automatic read_back_pressure();
  byte_t b;
  write_reg(ADDR_WINDOW_EXP, 8'd3);
  send_byte(byte_t'(ADDR_WINDOW_EXP));
  repeat (6) begin
    @(negedge clk);
    check_equal("read_back_pressure valid held", 1, dut_valid);
    check_equal("read_back_pressure data stable", 3, dut_data);
    check_equal("read_back_pressure ready low", 0, dut_ready);
  end
  recv_byte(b);
  check_equal("read_back_pressure data", 3, b);
  check_equal("read_back_pressure valid dropped", 0, dut_valid);
  check_equal("read_back_pressure ready back", 1, dut_ready);
endtask

task automatic fifo_flush_write();
  byte_t b;
  write_reg(ADDR_WINDOW_EXP, 8'd0);
  write_reg(ADDR_PERIOD_EXP, 8'd7);
  wait_for_level("fifo_flush_write", PKT, 2 * WIN_SLOW_CYCLES);
  write_reg(ADDR_FIFO_DATA, 8'h5a);
  read_reg(ADDR_FIFO_LEVEL, b);
  check_equal("fifo_flush_write level after flush", 0, b);
  read_reg(ADDR_FIFO_DATA, b);
  check_equal("fifo_flush_write empty pop", 0, b);
  read_reg(ADDR_FIFO_LEVEL, b);
  check_equal("fifo_flush_write level after empty pop", 0, b);
endtask

`endif

//--- test/tb_correlator.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module tb_correlator;
  import bp_pkg::*;
  import corr_pkg::*;

  localparam int CLK_PERIOD_NS    = 4;
  localparam int HANDSHAKE_LIMIT  = 50;
  localparam int BYTE_OP_CYCLES   = 8;
  localparam int DEPTH            = `CORR_PKTFIFO_DEPTH;
  localparam int PKT              = `CORR_PKT_BYTES;
  localparam int WIN_SHORT_CYCLES = (1 << 4) * (1 << 1);
  localparam int WIN_LONG_CYCLES  = (1 << 8) * (1 << 1);
  localparam int WIN_SLOW_CYCLES  = 1 << 7;
  // Worst case of each test in order, counting every register access as a full byte op.
  localparam int TEST_CYCLES = 16 * BYTE_OP_CYCLES
                             + 4 * WIN_SHORT_CYCLES + 40 * BYTE_OP_CYCLES
                             + 4 * WIN_SHORT_CYCLES + 2 * WIN_LONG_CYCLES + 60 * BYTE_OP_CYCLES
                             + 9 * WIN_SHORT_CYCLES + 70 * BYTE_OP_CYCLES
                             + 20 * BYTE_OP_CYCLES
                             + 2 * WIN_SLOW_CYCLES + 40 * BYTE_OP_CYCLES;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 200;

  logic  clk;
  logic  reset;
  logic  x;
  logic  y;
  byte_t host_data;
  logic  host_valid;
  logic  host_ready;
  byte_t dut_data;
  logic  dut_valid;
  logic  dut_ready;

  correlator i_dut (
    .i_clk      (clk),
    .i_reset    (reset),
    .i_x        (x),
    .i_y        (y),
    .i_bp_data  (host_data),
    .i_bp_valid (host_valid),
    .o_bp_ready (dut_ready),
    .o_bp_data  (dut_data),
    .o_bp_valid (dut_valid),
    .i_bp_ready (host_ready)
  );

  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_equal(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      stop_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  // Count bytes carry the top 8 bits of the count.
  function automatic int top_byte(input int count);
    return count >> (`CORR_TIME_W - 8);
  endfunction

  task automatic send_byte(input byte_t b);
    int waited;
    waited = 0;
    @(negedge clk);
    host_data  = b;
    host_valid = 1'b1;
    while (!dut_ready) begin
      if (waited == HANDSHAKE_LIMIT) begin
        stop_run("Timeout: the DUT never accepted a byte from the host.");
      end
      waited++;
      @(negedge clk);
    end
    @(negedge clk);
    host_valid = 1'b0;
    host_data  = '0;
  endtask

  task automatic recv_byte(output byte_t b);
    int waited;
    waited = 0;
    @(negedge clk);
    host_ready = 1'b1;
    while (!dut_valid) begin
      if (waited == HANDSHAKE_LIMIT) begin
        stop_run("Timeout: the DUT never returned a response byte.");
      end
      waited++;
      @(negedge clk);
    end
    b = dut_data;
    @(negedge clk);
    host_ready = 1'b0;
  endtask

  task automatic write_reg(input bp_addr_t addr, input byte_t data);
    send_byte(8'h80 | byte_t'(addr));
    send_byte(data);
  endtask

  task automatic read_reg(input bp_addr_t addr, output byte_t data);
    send_byte(byte_t'(addr));
    recv_byte(data);
  endtask

  `include "tb_tests.svh"

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    x          = 1'b0;
    y          = 1'b0;
    host_data  = '0;
    host_valid = 1'b0;
    host_ready = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    registers_after_reset();
    counts_x_only();
    counts_other_levels();
    fifo_overflow();
    read_back_pressure();
    fifo_flush_write();
    $display("All checks passed");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_run("Watchdog timeout: the test sequence did not finish in time.");
  end

endmodule
